// ==== include/sccb_regs.svh ====
// Sensor register table, written in order after cfg_start
// Entry format is {register, value}

// Write ID of the sensor
localparam logic [7:0] SCCB_ID = 8'h42;

localparam int SCCB_NUM_REGS = 8;

localparam logic [15:0] SCCB_REGS [SCCB_NUM_REGS] = '{
  16'h12_0C,  // COM7, RGB output
  16'h40_10,  // COM15, RGB565 range
  16'h11_01,  // Clock prescaler
  16'h1E_00,  // No mirror, no flip
  16'h3A_04,  // Output byte order
  16'h8C_00,  // RGB444 off
  16'h14_38,  // AGC ceiling
  16'h13_E7   // AEC, AGC, AWB on
};

// ==== hw/cam_video_pkg.sv ====
package cam_video_pkg;

  // Camera and frame buffer pixel, 16 bits
  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  // Display colour, 24 bits
  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb888_t;

  // Display output word, syncs active low
  typedef struct packed {
    logic    hsync;
    logic    vsync;
    logic    blank;
    rgb888_t colour;
  } video_t;

  // Capture to buffer write
  typedef struct packed {
    logic        we;     // Single-cycle strobe
    logic [14:0] addr;
    rgb565_t     pixel;
  } fb_wr_t;

  typedef enum logic [1:0] {
    CAP_WAIT_FRAME,
    CAP_BYTE_HI,
    CAP_BYTE_LO
  } cap_state_e;

  typedef enum logic [2:0] {
    SCCB_IDLE,
    SCCB_START,
    SCCB_SHIFT,
    SCCB_STOP,
    SCCB_GAP,
    SCCB_DONE
  } sccb_state_e;

endpackage

// ==== hw/sccb_config.sv ====
`timescale 1ns/100ps

module sccb_config #(
  parameter int SCCB_DIV = 63  // clk cycles per quarter SCL
) (
  input  logic clk,
  input  logic rst,
  input  logic start,
  output logic sioc,
  output logic siod,
  output logic done
);

  `include "sccb_regs.svh"

  localparam int DIV_W = $clog2(SCCB_DIV + 1);
  localparam int IDX_W = (SCCB_NUM_REGS > 1) ? $clog2(SCCB_NUM_REGS) : 1;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(SCCB_NUM_REGS - 1);

  cam_video_pkg::sccb_state_e state;
  logic [DIV_W-1:0] div_cnt;
  logic [1:0]       quarter;   // Quarter within one bit period
  logic [3:0]       bit_cnt;   // 0..8, bit 8 is the don't-care bit
  logic [1:0]       byte_cnt;  // ID, register, value
  logic [IDX_W-1:0] entry;
  logic             tick;
  logic             busy;
  logic [7:0]       cur_byte;
  logic [8:0]       cur_word;
  logic             sioc_d;
  logic             siod_d;

  assign tick = (div_cnt == DIV_W'(SCCB_DIV - 1));
  assign busy = (state != cam_video_pkg::SCCB_IDLE) && (state != cam_video_pkg::SCCB_DONE);

  always_comb begin
    case (byte_cnt)
      2'd0:    cur_byte = SCCB_ID;
      2'd1:    cur_byte = SCCB_REGS[entry][15:8];
      default: cur_byte = SCCB_REGS[entry][7:0];
    endcase
    cur_word = {cur_byte, 1'b1};  // MSB first, don't-care bit driven high
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= cam_video_pkg::SCCB_IDLE;
      div_cnt  <= '0;
      quarter  <= '0;
      bit_cnt  <= '0;
      byte_cnt <= '0;
      entry    <= '0;
    end else if (start && !busy) begin  // Launch or relaunch the table
      state   <= cam_video_pkg::SCCB_START;
      div_cnt <= '0;
      quarter <= '0;
      entry   <= '0;
    end else if (busy) begin
      if (tick) begin
        div_cnt <= '0;
        quarter <= quarter + 2'd1;
        if (quarter == 2'd3) begin  // End of a bit period
          case (state)
            cam_video_pkg::SCCB_START: begin
              state    <= cam_video_pkg::SCCB_SHIFT;
              bit_cnt  <= '0;
              byte_cnt <= '0;
            end
            cam_video_pkg::SCCB_SHIFT: begin
              if (bit_cnt == 4'd8) begin
                bit_cnt <= '0;
                if (byte_cnt == 2'd2) state <= cam_video_pkg::SCCB_STOP;
                else byte_cnt <= byte_cnt + 2'd1;
              end else begin
                bit_cnt <= bit_cnt + 4'd1;
              end
            end
            cam_video_pkg::SCCB_STOP: state <= cam_video_pkg::SCCB_GAP;
            cam_video_pkg::SCCB_GAP: begin
              if (entry == LAST_IDX) begin
                state <= cam_video_pkg::SCCB_DONE;
              end else begin
                entry <= entry + 1'b1;
                state <= cam_video_pkg::SCCB_START;
              end
            end
            default: state <= cam_video_pkg::SCCB_IDLE;
          endcase
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // Line levels per quarter; SIOD moves with SIOC low except at start/stop
  always_comb begin
    sioc_d = 1'b1;
    siod_d = 1'b1;
    case (state)
      cam_video_pkg::SCCB_START: begin
        sioc_d = (quarter < 2'd2);
        siod_d = (quarter == 2'd0);  // SIOD falls while SIOC high
      end
      cam_video_pkg::SCCB_SHIFT: begin
        sioc_d = (quarter == 2'd1) || (quarter == 2'd2);
        siod_d = cur_word[4'd8 - bit_cnt];
      end
      cam_video_pkg::SCCB_STOP: begin
        sioc_d = (quarter != 2'd0);
        siod_d = (quarter >= 2'd2);  // SIOD rises while SIOC high
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin  // Glitch-free line drivers
    if (rst) begin
      sioc <= 1'b1;
      siod <= 1'b1;
      done <= 1'b0;
    end else begin
      sioc <= sioc_d;
      siod <= siod_d;
      done <= (state == cam_video_pkg::SCCB_DONE);
    end
  end

endmodule

// ==== hw/cam_capture.sv ====
`timescale 1ns/100ps

module cam_capture #(
  parameter int CAM_W = 640,
  parameter int FB_W  = 160,
  parameter int FB_H  = 120
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cam_pclk,
  input  logic                  cam_vsync,
  input  logic                  cam_href,
  input  logic [7:0]            cam_data,
  output cam_video_pkg::fb_wr_t wr,
  output logic                  frame_done
);

  typedef struct packed {
    logic       pclk;
    logic       vsync;
    logic       href;
    logic [7:0] data;
  } cam_bus_t;

  cam_bus_t s1, s2, s3;            // Two sync stages plus edge stage
  logic       rise_q;              // Registered PCLK rise, aligned with s3
  logic       vsync_q, href_q;
  logic       vsync_fall, vsync_rise, href_fall;
  logic [7:0] hi_byte;
  logic [9:0] row, col;
  logic [14:0] dec_row, dec_col;
  logic       keep;
  cam_video_pkg::cap_state_e state;

  always_ff @(posedge clk) begin
    s1      <= {cam_pclk, cam_vsync, cam_href, cam_data};
    s2      <= s1;
    s3      <= s2;
    rise_q  <= s2.pclk & ~s3.pclk;
    vsync_q <= s3.vsync;
    href_q  <= s3.href;
  end

  assign vsync_fall = vsync_q & ~s3.vsync;  // Frame start
  assign vsync_rise = ~vsync_q & s3.vsync;  // Frame end
  assign href_fall  = href_q & ~s3.href;    // Line end

  // Keep every fourth pixel of every fourth row, inside the buffer
  assign dec_row = 15'(row[9:2]);
  assign dec_col = 15'(col[9:2]);
  assign keep = (row[1:0] == 2'd0) && (col[1:0] == 2'd0) && (col < 10'(CAM_W))
                && (dec_row < 15'(FB_H)) && (dec_col < 15'(FB_W));

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= cam_video_pkg::CAP_WAIT_FRAME;
      row        <= '0;
      col        <= '0;
      wr.we      <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      wr.we      <= 1'b0;
      frame_done <= vsync_rise;
      if (s3.vsync) begin
        state <= cam_video_pkg::CAP_WAIT_FRAME;
        row   <= '0;
        col   <= '0;
      end else begin
        case (state)
          cam_video_pkg::CAP_WAIT_FRAME: begin
            if (vsync_fall) state <= cam_video_pkg::CAP_BYTE_HI;
          end
          cam_video_pkg::CAP_BYTE_HI: begin
            if (href_fall) begin
              row <= row + 10'd1;
              col <= '0;
            end else if (rise_q && s3.href) begin
              hi_byte <= s3.data;  // High byte first
              state   <= cam_video_pkg::CAP_BYTE_LO;
            end
          end
          default: begin  // Low byte completes the pixel
            if (href_fall) begin
              row   <= row + 10'd1;
              col   <= '0;
              state <= cam_video_pkg::CAP_BYTE_HI;
            end else if (rise_q && s3.href) begin
              wr.we    <= keep;
              wr.addr  <= dec_row * 15'(FB_W) + dec_col;
              wr.pixel <= cam_video_pkg::rgb565_t'({hi_byte, s3.data});
              col      <= col + 10'd1;
              state    <= cam_video_pkg::CAP_BYTE_HI;
            end
          end
        endcase
      end
    end
  end

endmodule

// ==== hw/frame_buffer.sv ====
`timescale 1ns/100ps

module frame_buffer #(
  parameter int FB_W = 160,
  parameter int FB_H = 120
) (
  input  logic                   clk,
  input  cam_video_pkg::fb_wr_t  wr,
  input  logic [14:0]            raddr,
  output cam_video_pkg::rgb565_t rdata
);

  localparam int DEPTH  = FB_W * FB_H;
  localparam int ADDR_W = $clog2(DEPTH);

  cam_video_pkg::rgb565_t mem [DEPTH];

  logic [ADDR_W-1:0] waddr_i;  // Linear index into mem
  logic [ADDR_W-1:0] raddr_i;
  logic              wr_ok;
  logic              rd_ok;

  // Addresses past the last pixel are dropped on write
  assign wr_ok   = (wr.addr < 15'(DEPTH));
  assign rd_ok   = (raddr < 15'(DEPTH));
  assign waddr_i = ADDR_W'(wr.addr);
  assign raddr_i = rd_ok ? ADDR_W'(raddr) : '0;  // Out of range reads pixel 0

  always_ff @(posedge clk) begin  // Write port
    if (wr.we && wr_ok) begin
      mem[waddr_i] <= wr.pixel;
    end
  end

  // Read port, one clk latency, old data on a colliding write
  always_ff @(posedge clk) begin
    rdata <= mem[raddr_i];
  end

endmodule

// ==== hw/video_timing.sv ====
`timescale 1ns/100ps

module video_timing #(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  logic       clk,
  input  logic       rst,
  output logic [9:0] x,
  output logic [9:0] y,
  output logic       hsync,   // Active low
  output logic       vsync,   // Active low
  output logic       active
);

  localparam logic [9:0] H_TOTAL   = 10'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK);
  localparam logic [9:0] H_SYNC_LO = 10'(H_ACTIVE + H_FRONT);
  localparam logic [9:0] H_SYNC_HI = 10'(H_ACTIVE + H_FRONT + H_SYNC);
  localparam logic [9:0] V_TOTAL   = 10'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
  localparam logic [9:0] V_SYNC_LO = 10'(V_ACTIVE + V_FRONT);
  localparam logic [9:0] V_SYNC_HI = 10'(V_ACTIVE + V_FRONT + V_SYNC);

  logic [9:0] h_cnt, v_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_cnt == H_TOTAL - 10'd1) begin
      h_cnt <= '0;
      v_cnt <= (v_cnt == V_TOTAL - 10'd1) ? 10'd0 : v_cnt + 10'd1;  // Next line
    end else begin
      h_cnt <= h_cnt + 10'd1;
    end
  end

  // Registered decode, one clk behind the counters
  always_ff @(posedge clk) begin
    if (rst) begin
      x      <= '0;
      y      <= '0;
      hsync  <= 1'b1;
      vsync  <= 1'b1;
      active <= 1'b0;
    end else begin
      x      <= h_cnt;
      y      <= v_cnt;
      hsync  <= !((h_cnt >= H_SYNC_LO) && (h_cnt < H_SYNC_HI));
      vsync  <= !((v_cnt >= V_SYNC_LO) && (v_cnt < V_SYNC_HI));
      active <= (h_cnt < 10'(H_ACTIVE)) && (v_cnt < 10'(V_ACTIVE));
    end
  end

endmodule

// ==== hw/pixel_out.sv ====
`timescale 1ns/100ps

module pixel_out #(
  parameter int FB_W = 160
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [9:0]             x,
  input  logic [9:0]             y,
  input  logic                   hsync,
  input  logic                   vsync,
  input  logic                   active,
  output logic [14:0]            raddr,
  input  cam_video_pkg::rgb565_t rdata,
  output cam_video_pkg::video_t  video
);

  logic [14:0] dec_x, dec_y;
  logic        hsync_q, vsync_q, blank_q;  // Aligned with rdata
  cam_video_pkg::rgb888_t rgb;

  // Park at pixel 0 outside the display area
  assign dec_x = active ? 15'(x[9:2]) : 15'd0;
  assign dec_y = active ? 15'(y[9:2]) : 15'd0;
  assign raddr = dec_y * 15'(FB_W) + dec_x;  // Same layout as capture

  always_ff @(posedge clk) begin  // Match the one clk read latency
    if (rst) begin
      hsync_q <= 1'b1;
      vsync_q <= 1'b1;
      blank_q <= 1'b1;
    end else begin
      hsync_q <= hsync;
      vsync_q <= vsync;
      blank_q <= !active;
    end
  end

  always_comb begin
    rgb.red   = {rdata.red, 3'b000};    // Low bits zero filled
    rgb.green = {rdata.green, 2'b00};
    rgb.blue  = {rdata.blue, 3'b000};
  end

  always_comb begin
    video.hsync  = hsync_q;
    video.vsync  = vsync_q;
    video.blank  = blank_q;
    video.colour = blank_q ? '0 : rgb;  // Black outside the picture
  end

endmodule

// ==== hw/cam_video_top.sv ====
`timescale 1ns/100ps

module cam_video_top #(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33,
  parameter int CAM_W    = 640,
  parameter int FB_W     = 160,
  parameter int FB_H     = 120,
  parameter int SCCB_DIV = 63  // About 100 kHz SCL at 25 MHz
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cfg_start,
  input  logic                  cam_pclk,
  input  logic                  cam_vsync,
  input  logic                  cam_href,
  input  logic [7:0]            cam_data,
  output logic                  sioc,
  output logic                  siod,
  output logic                  cfg_done,
  output logic                  frame_done,
  output cam_video_pkg::video_t video
);

  cam_video_pkg::fb_wr_t  fb_wr;
  cam_video_pkg::rgb565_t fb_rdata;
  logic [14:0] fb_raddr;
  logic [9:0]  x, y;
  logic        hsync, vsync, active;

  sccb_config #(.SCCB_DIV(SCCB_DIV)) u_sccb (
    .clk(clk), .rst(rst), .start(cfg_start),
    .sioc(sioc), .siod(siod), .done(cfg_done)
  );

  cam_capture #(.CAM_W(CAM_W), .FB_W(FB_W), .FB_H(FB_H)) u_capture (
    .clk(clk), .rst(rst),
    .cam_pclk(cam_pclk), .cam_vsync(cam_vsync), .cam_href(cam_href), .cam_data(cam_data),
    .wr(fb_wr), .frame_done(frame_done)
  );

  frame_buffer #(.FB_W(FB_W), .FB_H(FB_H)) u_fb (
    .clk(clk), .wr(fb_wr), .raddr(fb_raddr), .rdata(fb_rdata)
  );

  video_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) u_timing (
    .clk(clk), .rst(rst), .x(x), .y(y),
    .hsync(hsync), .vsync(vsync), .active(active)
  );

  pixel_out #(.FB_W(FB_W)) u_pixel (
    .clk(clk), .rst(rst), .x(x), .y(y),
    .hsync(hsync), .vsync(vsync), .active(active),
    .raddr(fb_raddr), .rdata(fb_rdata), .video(video)
  );

endmodule

// ==== tb/cam_sensor_model.sv ====
`timescale 1ns/100ps

module cam_sensor_model #(
  parameter int          CAM_W = 64,
  parameter int          CAM_H = 48,
  parameter int unsigned SEED  = 1
) (
  input  logic       clk,
  input  logic       frame_go,    // Level that starts the one frame
  output logic       pclk,
  output logic       vsync,
  output logic       href,
  output logic [7:0] data,
  output logic       frame_sent,
  input  logic       sioc,
  input  logic       siod
);

  logic [15:0] pix [CAM_W*CAM_H];   // Reference copy of the frame
  logic [23:0] rx_list [64];        // Decoded {id, register, value}
  int          rx_count = 0;
  logic [26:0] shreg = '0;          // Three 9-bit phases
  int          bit_cnt = 0;
  logic        in_xfer = 1'b0;      // Between start and stop
  logic        sioc_q = 1'b1;
  logic        siod_q = 1'b1;

  // One byte per PCLK period at clk/4 with data moving on the PCLK fall
  task automatic send_byte(input logic h, input logic [7:0] d);
    @(negedge clk);
    pclk = 1'b0;
    href = h;
    data = d;
    @(negedge clk);
    @(negedge clk);
    pclk = 1'b1;  // Capture side samples here
    @(negedge clk);
  endtask

  task automatic idle_bytes(input int n);
    repeat (n) send_byte(1'b0, 8'h00);
  endtask

  initial begin
    void'($urandom(SEED));  // Fixed seed for the pixel data
    pclk       = 1'b0;
    vsync      = 1'b1;  // Held high until the frame starts
    href       = 1'b0;
    data       = 8'h00;
    frame_sent = 1'b0;
    wait (frame_go);
    for (int i = 0; i < CAM_W * CAM_H; i++) begin
      pix[i] = 16'($urandom);
    end
    idle_bytes(8);
    vsync = 1'b0;  // Frame start
    for (int r = 0; r < CAM_H; r++) begin
      idle_bytes(4);  // Horizontal gap with HREF low
      for (int c = 0; c < CAM_W; c++) begin
        send_byte(1'b1, pix[r*CAM_W + c][15:8]);  // High byte first
        send_byte(1'b1, pix[r*CAM_W + c][7:0]);
      end
    end
    idle_bytes(4);
    vsync = 1'b1;  // Frame end
    idle_bytes(8);
    frame_sent = 1'b1;
  end

  // SCCB write decoder taking bits on the SIOC rise
  always @(negedge clk) begin
    sioc_q <= sioc;
    siod_q <= siod;
    if (sioc && sioc_q && siod_q && !siod) begin  // Start condition
      in_xfer <= 1'b1;
      bit_cnt <= 0;
    end else if (sioc && sioc_q && !siod_q && siod) begin  // Stop condition
      if (in_xfer && bit_cnt == 27 && rx_count < 64) begin
        rx_list[rx_count] <= {shreg[26:19], shreg[17:10], shreg[8:1]};
        rx_count          <= rx_count + 1;
      end
      in_xfer <= 1'b0;
    end else if (sioc && !sioc_q && in_xfer && bit_cnt < 27) begin
      shreg   <= {shreg[25:0], siod};
      bit_cnt <= bit_cnt + 1;  // Stop's own SIOC rise is not a bit
    end
  end

endmodule

// ==== tb/cam_video_tb.sv ====
`timescale 1ns/100ps

module cam_video_tb;

  `include "sccb_regs.svh"

  localparam int H_ACTIVE = 64;
  localparam int H_FRONT  = 4;
  localparam int H_SYNC   = 8;
  localparam int H_BACK   = 4;
  localparam int V_ACTIVE = 48;
  localparam int V_FRONT  = 2;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 2;
  localparam int CAM_W    = 64;
  localparam int CAM_H    = 48;
  localparam int FB_W     = 16;
  localparam int FB_H     = 12;
  localparam int SCCB_DIV = 2;
  localparam int unsigned SEED = 6584;
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int SCCB_CYC = SCCB_NUM_REGS * 30 * 4 * SCCB_DIV;  // 30 bit periods per entry
  localparam int CAM_CYC  = 4 * (CAM_H * (2 * CAM_W + 4) + 24);  // 4 clk per byte
  localparam int TIMEOUT_CYC = 2 * (16 + SCCB_CYC + CAM_CYC + 3 * H_TOTAL * V_TOTAL);

  logic clk, rst, cfg_start, frame_go, frame_sent;
  logic cam_pclk, cam_vsync, cam_href;
  logic [7:0] cam_data;
  logic sioc, siod, cfg_done, frame_done;
  cam_video_pkg::video_t video;

  int errors = 0;
  int checks = 0;
  int unsigned cycles = 0;
  int hs_low = 0;
  int hs_period = 0;
  int act_cnt = 0;
  int vs_low = 0;
  int fd_count = 0;
  logic hs_prev = 1'b1;
  logic hs_seen = 1'b0;
  logic done_prev = 1'b0;
  logic mon_en = 1'b0;
  logic line_c_q = 1'b1;
  logic line_d_q = 1'b1;

  cam_video_top #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
    .CAM_W(CAM_W), .FB_W(FB_W), .FB_H(FB_H), .SCCB_DIV(SCCB_DIV)
  ) DUT (
    .clk(clk), .rst(rst), .cfg_start(cfg_start),
    .cam_pclk(cam_pclk), .cam_vsync(cam_vsync), .cam_href(cam_href), .cam_data(cam_data),
    .sioc(sioc), .siod(siod), .cfg_done(cfg_done), .frame_done(frame_done), .video(video)
  );

  cam_sensor_model #(.CAM_W(CAM_W), .CAM_H(CAM_H), .SEED(SEED)) sensor (
    .clk(clk), .frame_go(frame_go), .pclk(cam_pclk), .vsync(cam_vsync),
    .href(cam_href), .data(cam_data), .frame_sent(frame_sent), .sioc(sioc), .siod(siod)
  );

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, exp, got);
    end
  endtask

  task automatic require_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("ERROR t=%0t %s", $time, what);
    end
  endtask

  // RGB565 to 888 with zero low bits
  function automatic cam_video_pkg::rgb888_t expand_rgb565(input logic [15:0] p);
    cam_video_pkg::rgb888_t c;
    c.red   = {p[15:11], 3'b000};
    c.green = {p[10:5], 2'b00};
    c.blue  = {p[4:0], 3'b000};
    return c;
  endfunction

  task automatic verify_reset_state();
    compare_value("sioc", 32'(sioc), 1);
    compare_value("siod", 32'(siod), 1);
    compare_value("cfg_done", 32'(cfg_done), 0);
    compare_value("frame_done", 32'(frame_done), 0);
    compare_value("video.blank", 32'(video.blank), 1);
    compare_value("video.hsync", 32'(video.hsync), 1);
    compare_value("video.vsync", 32'(video.vsync), 1);
    compare_value("video.colour", 32'(video.colour), 0);
  endtask

  task automatic match_sccb_writes();
    compare_value("sccb entries", sensor.rx_count, SCCB_NUM_REGS);
    for (int i = 0; i < SCCB_NUM_REGS; i++) begin
      compare_value("sccb id", 32'(sensor.rx_list[i][23:16]), 32'h42);
      compare_value("sccb register", 32'(sensor.rx_list[i][15:8]), 32'(SCCB_REGS[i][15:8]));
      compare_value("sccb value", 32'(sensor.rx_list[i][7:0]), 32'(SCCB_REGS[i][7:0]));
    end
  endtask

  // One whole display frame against the decimated sensor frame
  task automatic scan_display_frame();
    int xx;
    int yy;
    int idx;
    logic prev_blank;
    cam_video_pkg::rgb888_t exp_rgb;
    while (video.vsync !== 1'b0) @(negedge clk);
    while (video.vsync !== 1'b1) @(negedge clk);  // Next lines start at y 0
    xx = 0;
    yy = 0;
    prev_blank = 1'b1;
    while (yy < V_ACTIVE) begin
      @(negedge clk);
      if (!video.blank) begin
        idx     = 4 * (yy / 4) * CAM_W + 4 * (xx / 4);
        exp_rgb = expand_rgb565(sensor.pix[idx]);
        compare_value("video.colour", 32'(video.colour), 32'(exp_rgb));
        xx++;
      end else if (!prev_blank) begin  // End of an active line
        yy++;
        xx = 0;
      end
      prev_blank = video.blank;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cycles <= cycles + 1;

  initial begin
    while (cycles < TIMEOUT_CYC) @(posedge clk);
    $display("Timeout after %0d cycles, the DUT never reached the end of the test", cycles);
    $display("CHECKS FAILED");
    $finish;
  end

  // Timing, blank gating and SCCB line monitors
  always @(negedge clk) begin
    if (mon_en) begin
      if (video.blank) compare_value("video.colour", 32'(video.colour), 0);
      if (!video.blank) act_cnt++;
      if (!video.hsync) begin
        hs_low++;
      end else if (hs_low != 0) begin
        compare_value("hsync low width", hs_low, H_SYNC);
        hs_low = 0;
      end
      if (!video.hsync && hs_prev) begin  // hsync fall
        if (hs_seen) compare_value("hsync period", hs_period, H_TOTAL);
        if (act_cnt != 0) compare_value("active cycles per line", act_cnt, H_ACTIVE);
        hs_seen   = 1'b1;
        hs_period = 1;
        act_cnt   = 0;
      end else begin
        hs_period++;
      end
      hs_prev = video.hsync;
      if (!video.vsync) begin
        vs_low++;
      end else if (vs_low != 0) begin
        compare_value("vsync low width", vs_low, V_SYNC * H_TOTAL);
        vs_low = 0;
      end
      if (frame_done) fd_count++;
      if (sioc && line_c_q && siod != line_d_q) begin
        require_true((!siod && !sensor.in_xfer) ||
                     (siod && sensor.in_xfer && sensor.bit_cnt == 27),
                     "SIOD changed while SIOC was high outside a start or stop condition");
      end
      if (cfg_done && !done_prev) begin
        require_true(sensor.rx_count == SCCB_NUM_REGS && !sensor.in_xfer,
                     "cfg_done rose before the last stop condition");
      end
      done_prev = cfg_done;
      line_c_q  = sioc;
      line_d_q  = siod;
    end
  end

  initial begin
    rst       = 1'b1;
    cfg_start = 1'b0;
    frame_go  = 1'b0;
    repeat (16) begin
      @(negedge clk);
      verify_reset_state();
    end
    rst = 1'b0;
    @(negedge clk);
    verify_reset_state();
    mon_en = 1'b1;
    cfg_start = 1'b1;  // Configure the sensor
    @(negedge clk);
    cfg_start = 1'b0;
    while (cfg_done !== 1'b1) @(negedge clk);
    match_sccb_writes();
    frame_go = 1'b1;  // One camera frame
    while (frame_done !== 1'b1) @(negedge clk);
    scan_display_frame();
    while (frame_sent !== 1'b1) @(negedge clk);  // Whole sensor frame is out
    compare_value("frame_done pulses", fd_count, 1);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== cam_video.f ====
+incdir+include
hw/cam_video_pkg.sv
hw/sccb_config.sv
hw/cam_capture.sv
hw/frame_buffer.sv
hw/video_timing.sv
hw/pixel_out.sv
hw/cam_video_top.sv
tb/cam_sensor_model.sv
tb/cam_video_tb.sv

// ==== Makefile ====
# Verilator build and run of the camera video testbench

VERILATOR  ?= verilator
TOP        ?= cam_video_tb
FILELIST   ?= cam_video.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= ALL CHECKS PASSED
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Pass or fail comes from the log, not the simulator's exit code
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
